// File: run.sh
#!/bin/sh
# compile and run the video output testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_video_top \
    -f sim.f \
    -o sim_tb

./obj_dir/sim_tb

// File: sim.f
verilog/video_pkg.sv
verilog/sync_vg.sv
verilog/hdmi_pack.sv
verilog/hdmi_display.sv
verilog/disp_regs.sv
verilog/video_top.sv
testbench/tb_video_top.sv

// File: testbench/tb_video_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_video_top;

    // small frame, 15 clocks per line, 7 lines
    localparam int H_SYNC     = 2;
    localparam int H_START    = 5;  // sync + back porch
    localparam int H_ACT      = 8;
    localparam int H_TOTAL    = 15;
    localparam int V_SYNC     = 1;
    localparam int V_START    = 2;
    localparam int V_ACT      = 4;
    localparam int V_TOTAL    = 7;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
    localparam int CAM_PERIOD = 105;
    localparam int APB_LIMIT  = 16;
    localparam int ROW_CNT    = 5;

    localparam video_pkg::timing_t TB_TIMING = '{
        h_fp   : 12'd2,
        h_bp   : 12'd3,
        h_sync : 12'd2,
        h_act  : 12'd8,
        v_fp   : 12'd1,
        v_bp   : 12'd1,
        v_sync : 12'd1,
        v_act  : 12'd4
    };

    typedef struct packed {
        logic [31:0] ctrl;
        logic [23:0] solid;
        logic [7:0]  frames;
    } row_t;

    logic                 clk;
    logic                 rstn;
    logic                 i_psel;
    logic                 i_penable;
    logic                 i_pwrite;
    logic [3:0]           i_paddr;
    logic [31:0]          i_pwdata;
    logic [31:0]          o_prdata;
    logic                 o_pready;
    logic                 o_pslverr;
    logic                 i_vsync;
    logic [15:0]          i_data;
    video_pkg::pix_pack_t o_pack;

    row_t rows [0:ROW_CNT-1];
    int   cam_cnt;

    // reference model state
    int                   h_m;
    int                   v_m;
    logic                 run_m;
    logic                 vs_prev_m;
    logic                 en_m;
    logic                 src_m;
    video_pkg::rgb_t      solid_m;
    logic                 de_m;
    video_pkg::pix_pack_t nxt_pack;
    video_pkg::pix_pack_t exp_pack;
    logic [15:0]          sof_cnt;

    video_top #(
        .TIMING (TB_TIMING)
    ) DUT (
        .clk       (clk),
        .rstn      (rstn),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_vsync   (i_vsync),
        .i_data    (i_data),
        .o_pack    (o_pack)
    );

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic video_pkg::rgb_t expand_565(input logic [15:0] d);
        video_pkg::rgb_t c;
        c.r = {d[4:0], 3'b000};
        c.g = {d[10:5], 2'b00};
        c.b = {d[15:11], 3'b000};
        return c;
    endfunction

    task automatic run_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
        end
    endtask

    // setup, access, then release on the edge that ends the access
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        int wait_cnt;
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge clk);
        i_penable <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!o_pready) begin
            wait_cnt++;
            if (wait_cnt > APB_LIMIT) begin
                $display("APB access phase never completed at address %0h", addr);
                abort_run();
            end
            @(negedge clk);
        end
        rdata  = o_prdata;
        slverr = o_pslverr;
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_eq("o_pslverr", 32'(exp_err), 32'(err));
    endtask

    task automatic reg_read(input logic [3:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check_eq("o_pslverr", 32'(exp_err), 32'(err));
        check_eq("o_prdata", exp_data, rd);
    endtask

    task automatic wait_frames(input int n);
        int target;
        int guard;
        target = int'(sof_cnt) + n;
        guard  = 0;
        while (int'(sof_cnt) < target) begin
            @(negedge clk);
            guard++;
            if (guard > (n + 2) * FRAME_CLKS) begin
                $display("no start of frame seen within %0d clocks", guard);
                abort_run();
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // camera side

    always @(posedge clk) begin
        cam_cnt <= (cam_cnt == CAM_PERIOD - 1) ? 0 : cam_cnt + 1;
        i_vsync <= (cam_cnt >= 50) && (cam_cnt < 53); // 3 clock pulse
        i_data  <= 16'($urandom);
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model

    always_comb begin
        de_m = run_m && (h_m >= H_START) && (h_m < H_START + H_ACT) &&
               (v_m >= V_START) && (v_m < V_START + V_ACT);
        nxt_pack       = '0;
        nxt_pack.hsync = run_m && (h_m < H_SYNC);
        nxt_pack.vsync = run_m && (v_m < V_SYNC);
        nxt_pack.de    = de_m;
        if (de_m) begin
            nxt_pack.x   = 11'(h_m - H_START);
            nxt_pack.y   = 10'(v_m - V_START);
            nxt_pack.rgb = src_m ? solid_m : expand_565(i_data);
            nxt_pack.sof = (h_m == H_START) && (v_m == V_START);
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            h_m       <= 0;
            v_m       <= 0;
            run_m     <= 1'b0;
            vs_prev_m <= 1'b0;
            en_m      <= 1'b0;
            src_m     <= 1'b0;
            solid_m   <= '0;
            exp_pack  <= '0;
            sof_cnt   <= '0;
        end else begin
            exp_pack  <= nxt_pack;
            vs_prev_m <= i_vsync;
            if (exp_pack.sof) begin
                sof_cnt <= sof_cnt + 16'd1;
            end
            if (!run_m) begin
                h_m <= 0;
                v_m <= 0;
                if (en_m && !vs_prev_m && i_vsync) begin
                    run_m <= 1'b1; // release clock
                end
            end else begin
                h_m <= (h_m == H_TOTAL - 1) ? 0 : h_m + 1;
                if (h_m == H_TOTAL - 1) begin
                    v_m <= (v_m == V_TOTAL - 1) ? 0 : v_m + 1;
                end
            end
            if (i_psel && i_penable && i_pwrite) begin
                if (i_paddr == video_pkg::ADDR_CTRL) begin
                    en_m  <= i_pwdata[0];
                    src_m <= i_pwdata[1];
                end else if (i_paddr == video_pkg::ADDR_SOLID) begin
                    solid_m <= i_pwdata[23:0];
                end
            end
        end
    end

    // outputs compared away from the active edge
    always @(negedge clk) begin
        if (rstn) begin
            check_eq("o_pack.sof", 32'(exp_pack.sof), 32'(o_pack.sof));
            check_eq("o_pack.vsync", 32'(exp_pack.vsync), 32'(o_pack.vsync));
            check_eq("o_pack.hsync", 32'(exp_pack.hsync), 32'(o_pack.hsync));
            check_eq("o_pack.de", 32'(exp_pack.de), 32'(o_pack.de));
            check_eq("o_pack.rgb", 32'(exp_pack.rgb), 32'(o_pack.rgb));
            check_eq("o_pack.x", 32'(exp_pack.x), 32'(o_pack.x));
            check_eq("o_pack.y", 32'(exp_pack.y), 32'(o_pack.y));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence

    initial begin
        logic [15:0] cnt_snap;
        void'($urandom(82));
        clk       = 1'b0;
        rstn      = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        i_vsync   = 1'b0;
        i_data    = '0;
        cam_cnt   = 0;

        rows[0] = '{ctrl: 32'h0000_0001, solid: 24'h000000, frames: 8'd2};
        rows[1] = '{ctrl: 32'h0000_0003, solid: 24'hff8010, frames: 8'd1};
        rows[2] = '{ctrl: 32'hf000_0001, solid: 24'h123456, frames: 8'd2};
        rows[3] = '{ctrl: 32'h0000_0002, solid: 24'h00ff00, frames: 8'd1}; // enable off, still runs
        rows[4] = '{ctrl: 32'h0000_0003, solid: 24'h5aa5c3, frames: 8'd1};

        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        // registers while the generator is held
        reg_read(video_pkg::ADDR_CTRL, 32'h0, 1'b0);
        reg_read(video_pkg::ADDR_STATUS, 32'h0, 1'b0);
        reg_write(video_pkg::ADDR_SOLID, 32'hdea1_b2c3, 1'b0);
        reg_read(video_pkg::ADDR_SOLID, 32'h00a1_b2c3, 1'b0);
        reg_write(video_pkg::ADDR_CTRL, 32'h0000_0002, 1'b0);
        reg_read(video_pkg::ADDR_CTRL, 32'h0000_0002, 1'b0);
        reg_write(video_pkg::ADDR_STATUS, 32'h0000_beef, 1'b0);
        reg_read(video_pkg::ADDR_STATUS, 32'h0, 1'b0);
        reg_write(4'hc, 32'h0000_0001, 1'b1);
        reg_read(4'hc, 32'h0, 1'b1);
        reg_read(video_pkg::ADDR_CTRL, 32'h0000_0002, 1'b0);

        run_cycles(2 * CAM_PERIOD + 20); // vsync pulses while disabled

        for (int i = 0; i < ROW_CNT; i++) begin
            reg_write(video_pkg::ADDR_SOLID, {8'h00, rows[i].solid}, 1'b0);
            reg_write(video_pkg::ADDR_CTRL, rows[i].ctrl, 1'b0);
            reg_read(video_pkg::ADDR_CTRL, rows[i].ctrl & 32'h3, 1'b0);
            reg_read(video_pkg::ADDR_SOLID, {8'h00, rows[i].solid}, 1'b0);
            wait_frames(int'(rows[i].frames));
            reg_read(video_pkg::ADDR_STATUS, 32'(sof_cnt), 1'b0);
        end

        // frame count survives a write
        wait_frames(1);
        cnt_snap = sof_cnt;
        reg_write(video_pkg::ADDR_STATUS, 32'h0000_1234, 1'b0);
        reg_read(video_pkg::ADDR_STATUS, 32'(cnt_snap), 1'b0);

        $display("No errors");
        $finish;
    end

endmodule : tb_video_top

`default_nettype wire

// File: verilog/disp_regs.sv
`timescale 1ns/100ps
`default_nettype none

module disp_regs (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              i_psel,
    input  wire                              i_penable,
    input  wire                              i_pwrite,
    input  wire  [video_pkg::APB_AW-1:0]     i_paddr,
    input  wire  [video_pkg::APB_DW-1:0]     i_pwdata,
    input  wire                              i_sof,

    output logic [video_pkg::APB_DW-1:0]     o_prdata,
    output logic                             o_pready,
    output logic                             o_pslverr,
    output video_pkg::disp_cfg_t             o_cfg
);

    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic [15:0] frame_cnt;

    // ~~~~~~~~~~~~~~~~~~~~
    // decode

    assign access  = i_psel && i_penable;
    assign addr_ok = (i_paddr == video_pkg::ADDR_CTRL)  ||
                     (i_paddr == video_pkg::ADDR_SOLID) ||
                     (i_paddr == video_pkg::ADDR_STATUS);
    assign wr_en   = access && i_pwrite && addr_ok;

    assign o_pready  = 1'b1;             // no wait states
    assign o_pslverr = access && !addr_ok;

    // ~~~~~~~~~~~~~~~~~~~~
    // registers

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_cfg <= '0;
        end else if (wr_en) begin
            case (i_paddr)
                video_pkg::ADDR_CTRL: begin
                    o_cfg.enable <= i_pwdata[0];
                    o_cfg.src    <= video_pkg::src_e'(i_pwdata[1]);
                end
                video_pkg::ADDR_SOLID: begin
                    o_cfg.solid <= i_pwdata[23:0]; // r in the high byte
                end
                default: begin
                    // status is read only
                end
            endcase
        end
    end

    // counts sof pulses, wraps at 16 bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_cnt <= '0;
        end else if (i_sof) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read mux

    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            video_pkg::ADDR_CTRL:   o_prdata[1:0]  = {o_cfg.src, o_cfg.enable};
            video_pkg::ADDR_SOLID:  o_prdata[23:0] = o_cfg.solid;
            video_pkg::ADDR_STATUS: o_prdata[15:0] = frame_cnt;
            default:                o_prdata       = '0; // unmapped reads zero
        endcase
    end

    a_penable_psel : assert property (
        @(posedge clk) disable iff (!rstn)
        i_penable |-> i_psel
    );

endmodule : disp_regs

`default_nettype wire

// File: verilog/hdmi_display.sv
`timescale 1ns/100ps
`default_nettype none

module hdmi_display #(
    parameter video_pkg::timing_t TIMING = video_pkg::TIMING_720P
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              i_vsync,
    input  wire  [15:0]                      i_data,
    input  wire  video_pkg::disp_cfg_t       i_cfg,

    output video_pkg::pix_pack_t             o_pack,
    output logic                             o_sof
);

    logic                          run;
    logic                          vsync_d;
    logic                          hsync;
    logic                          vsync;
    logic                          de;
    logic [video_pkg::X_BITS-1:0]  x;
    logic [video_pkg::Y_BITS-1:0]  y;

    // ~~~~~~~~~~~~~~~~~~~~
    // start on camera vsync rise

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run     <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= i_vsync;
            if (!run && i_cfg.enable && !vsync_d && i_vsync) begin
                run <= 1'b1; // sticky until reset
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // timing and packing

    sync_vg #(
        .TIMING (TIMING)
    ) u_sync_vg (
        .clk     (clk),
        .rstn    (rstn),
        .i_run   (run),
        .o_hsync (hsync),
        .o_vsync (vsync),
        .o_de    (de),
        .o_x     (x),
        .o_y     (y)
    );

    hdmi_pack u_hdmi_pack (
        .clk     (clk),
        .rstn    (rstn),
        .i_hsync (hsync),
        .i_vsync (vsync),
        .i_de    (de),
        .i_x     (x),
        .i_y     (y),
        .i_data  (i_data), // camera assumed pixel locked
        .i_cfg   (i_cfg),
        .o_pack  (o_pack)
    );

    assign o_sof = o_pack.sof;

endmodule : hdmi_display

`default_nettype wire

// File: verilog/hdmi_pack.sv
`timescale 1ns/100ps
`default_nettype none

module hdmi_pack (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              i_hsync,
    input  wire                              i_vsync,
    input  wire                              i_de,
    input  wire  [video_pkg::X_BITS-1:0]     i_x,
    input  wire  [video_pkg::Y_BITS-1:0]     i_y,
    input  wire  [15:0]                      i_data,
    input  wire  video_pkg::disp_cfg_t       i_cfg,

    output video_pkg::pix_pack_t             o_pack
);

    video_pkg::rgb_t      cam_rgb;
    video_pkg::rgb_t      src_rgb;
    video_pkg::pix_pack_t pack_d;

    // rgb565 to 888, low bits zero
    assign cam_rgb = '{
        r : {i_data[4:0],   3'b000},
        g : {i_data[10:5],  2'b00},
        b : {i_data[15:11], 3'b000}
    };

    assign src_rgb = (i_cfg.src == video_pkg::SRC_SOLID) ? i_cfg.solid : cam_rgb;

    always_comb begin
        pack_d.sof   = i_de && (i_x == '0) && (i_y == '0);
        pack_d.vsync = i_vsync;
        pack_d.hsync = i_hsync;
        pack_d.de    = i_de;
        pack_d.rgb   = i_de ? src_rgb : '0; // blank outside de
        pack_d.x     = i_x;
        pack_d.y     = i_y;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_pack <= '0;
        end else begin
            o_pack <= pack_d;
        end
    end

    // blanking seen one cycle later at the output
    a_blank : assert property (
        @(posedge clk) disable iff (!rstn)
        !i_de |=> (o_pack.rgb == '0)
    );

endmodule : hdmi_pack

`default_nettype wire

// File: verilog/sync_vg.sv
`timescale 1ns/100ps
`default_nettype none

module sync_vg #(
    parameter video_pkg::timing_t TIMING = video_pkg::TIMING_720P
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              i_run,

    output logic                             o_hsync,
    output logic                             o_vsync,
    output logic                             o_de,
    output logic [video_pkg::X_BITS-1:0]     o_x,
    output logic [video_pkg::Y_BITS-1:0]     o_y
);

    localparam int H_TOTAL = TIMING.h_fp + TIMING.h_bp + TIMING.h_sync + TIMING.h_act;
    localparam int V_TOTAL = TIMING.v_fp + TIMING.v_bp + TIMING.v_sync + TIMING.v_act;

    // active window follows sync and back porch
    localparam int H_START = TIMING.h_sync + TIMING.h_bp;
    localparam int H_END   = H_START + TIMING.h_act;
    localparam int V_START = TIMING.v_sync + TIMING.v_bp;
    localparam int V_END   = V_START + TIMING.v_act;

    logic [video_pkg::CNT_W-1:0] h_cnt;
    logic [video_pkg::CNT_W-1:0] v_cnt;
    logic [video_pkg::CNT_W-1:0] h_off;
    logic [video_pkg::CNT_W-1:0] v_off;
    logic                        h_last;
    logic                        v_last;
    logic                        h_act;
    logic                        v_act;

    // ~~~~~~~~~~~~~~~~~~~~
    // counters

    assign h_last = (h_cnt == H_TOTAL - 1);
    assign v_last = (v_cnt == V_TOTAL - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!i_run) begin
            h_cnt <= '0; // held until started
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // decode

    assign h_act = (h_cnt >= H_START) && (h_cnt < H_END);
    assign v_act = (v_cnt >= V_START) && (v_cnt < V_END);

    assign h_off = h_cnt - H_START[video_pkg::CNT_W-1:0];
    assign v_off = v_cnt - V_START[video_pkg::CNT_W-1:0];

    assign o_hsync = i_run && (h_cnt < TIMING.h_sync);
    assign o_vsync = i_run && (v_cnt < TIMING.v_sync);
    assign o_de    = i_run && h_act && v_act;

    // coordinates only inside the active area
    assign o_x = o_de ? h_off[video_pkg::X_BITS-1:0] : '0;
    assign o_y = o_de ? v_off[video_pkg::Y_BITS-1:0] : '0;

    // ~~~~~~~~~~~~~~~~~~~~
    // checks

    a_cnt_range : assert property (
        @(posedge clk) disable iff (!rstn)
        (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL)
    );

    a_de_hsync : assert property (
        @(posedge clk) disable iff (!rstn)
        !(o_de && o_hsync)
    );

endmodule : sync_vg

`default_nettype wire

// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // video timing

    localparam int X_BITS = 11;
    localparam int Y_BITS = 10;
    localparam int CNT_W  = 14; // fits the sum of four 12-bit fields

    typedef struct packed {
        logic [11:0] h_fp;
        logic [11:0] h_bp;
        logic [11:0] h_sync;
        logic [11:0] h_act;
        logic [11:0] v_fp;
        logic [11:0] v_bp;
        logic [11:0] v_sync;
        logic [11:0] v_act;
    } timing_t;

    // 1280x720, line total 1892, frame total 740
    localparam timing_t TIMING_720P = '{
        h_fp   : 12'd300,
        h_bp   : 12'd300,
        h_sync : 12'd12,
        h_act  : 12'd1280,
        v_fp   : 12'd8,
        v_bp   : 12'd10,
        v_sync : 12'd2,
        v_act  : 12'd720
    };

    // ~~~~~~~~~~~~~~~~~~~~
    // pixel word

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic              sof;    // first active pixel of frame
        logic              vsync;
        logic              hsync;
        logic              de;
        rgb_t              rgb;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } pix_pack_t;                  // 49 bits

    typedef enum logic {
        SRC_CAMERA = 1'b0,
        SRC_SOLID  = 1'b1
    } src_e;

    typedef struct packed {
        logic enable;
        src_e src;
        rgb_t solid;
    } disp_cfg_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // register map

    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_SOLID  = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h8; // frame count, read only

endpackage : video_pkg

`default_nettype wire

// File: verilog/video_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_top #(
    parameter video_pkg::timing_t TIMING = video_pkg::TIMING_720P
) (
    input  wire                              clk,
    input  wire                              rstn,

    // apb
    input  wire                              i_psel,
    input  wire                              i_penable,
    input  wire                              i_pwrite,
    input  wire  [video_pkg::APB_AW-1:0]     i_paddr,
    input  wire  [video_pkg::APB_DW-1:0]     i_pwdata,
    output logic [video_pkg::APB_DW-1:0]     o_prdata,
    output logic                             o_pready,
    output logic                             o_pslverr,

    // camera
    input  wire                              i_vsync,
    input  wire  [15:0]                      i_data,

    output video_pkg::pix_pack_t             o_pack
);

    video_pkg::disp_cfg_t cfg;
    logic                 sof;

    disp_regs u_disp_regs (
        .clk       (clk),
        .rstn      (rstn),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .i_sof     (sof),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_cfg     (cfg)
    );

    hdmi_display #(
        .TIMING (TIMING)
    ) u_hdmi_display (
        .clk     (clk),
        .rstn    (rstn),
        .i_vsync (i_vsync),
        .i_data  (i_data),
        .i_cfg   (cfg),
        .o_pack  (o_pack),
        .o_sof   (sof)
    );

endmodule : video_top

`default_nettype wire
